/* camera_config.f */
src/camera_config_pkg.sv
src/reg_script_rom.sv
src/i2c_master.sv
src/config_sequencer.sv
src/camera_config_top.sv
verification/sensor_i2c_model.sv
verification/camera_config_props.sv
verification/camera_config_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator and run; a $fatal in the testbench gives a non-zero exit status
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wall -Wno-fatal \
   -f camera_config.f \
   --top-module camera_config_tb \
   -o camera_config_sim \
   && ./obj_dir/camera_config_sim \
   || exit 1
exit 0

/* src/camera_config_pkg.sv */
package camera_config_pkg;

   localparam int SCRIPT_LEN     = 24;
   localparam int BUS_GAP_CYCLES = 3;          // idle clocks between transactions
   localparam int QUARTER_CYCLES = 1;          // clocks per quarter scl period

   typedef logic [7:0]  i2c_addr_t;            // 7-bit address << 1, r/w bit zero
   typedef logic [15:0] reg_addr_t;
   typedef logic [7:0]  reg_data_t;
   typedef logic [$clog2(SCRIPT_LEN)-1:0]       script_idx_t;
   typedef logic [$clog2(QUARTER_CYCLES+1)-1:0] tick_cnt_t;

   localparam i2c_addr_t SENSOR_ADDR  = 8'h6c;
   localparam reg_addr_t ID_REG       = 16'h300b;
   localparam reg_data_t EXPECTED_ID  = 8'h88;
   localparam i2c_addr_t DELAY_MARKER = 8'hAA; // address field of a pause entry

   // one line of the register script
   typedef struct packed {
      i2c_addr_t slave_addr;
      reg_addr_t reg_addr;
      reg_data_t data;
   } script_entry_t;

   typedef enum logic [1:0] {
      OP_WRITE_PTR,                            // addr + 16-bit pointer
      OP_WRITE_WORD,                           // addr + pointer + data byte
      OP_READ_BYTE                             // addr with r/w set, one byte, nack
   } i2c_op_t;

   typedef struct packed {
      i2c_op_t   op;
      i2c_addr_t slave_addr;
      reg_addr_t reg_addr;
      reg_data_t wdata;
   } i2c_cmd_t;

   typedef enum logic [3:0] {
      SEQ_PTR,
      SEQ_PTR_WAIT,
      SEQ_PTR_GAP,
      SEQ_READ,
      SEQ_READ_WAIT,
      SEQ_ID_GAP,
      SEQ_FETCH,
      SEQ_ENTRY,
      SEQ_WORD_WAIT,
      SEQ_GAP,
      SEQ_DELAY,
      SEQ_DONE
   } seq_state_t;

   typedef enum logic [1:0] {
      I2C_IDLE,
      I2C_START,
      I2C_BIT,
      I2C_STOP
   } i2c_state_t;

endpackage

/* src/camera_config_top.sv */
`timescale 1ns/1ps

module camera_config_top (
   input  logic                         CLK_400K,
   input  logic                         RESET_N,
   input  logic                         sda_in,
   output logic                         i2c_scl,
   output logic                         sda_pull_low,
   output logic                         config_done,
   output camera_config_pkg::reg_data_t chip_id
);

   import camera_config_pkg::*;

   i2c_cmd_t      cmd;
   logic          start;
   logic          done;
   reg_data_t     rdata;
   script_idx_t   script_idx;
   script_entry_t entry;

   config_sequencer config_sequencer_inst (
      .CLK_400K    (CLK_400K),
      .RESET_N     (RESET_N),
      .cmd         (cmd),
      .start       (start),
      .done        (done),
      .rdata       (rdata),
      .script_idx  (script_idx),
      .entry       (entry),
      .chip_id     (chip_id),
      .config_done (config_done)
   );

   reg_script_rom reg_script_rom_inst (
      .CLK_400K   (CLK_400K),
      .script_idx (script_idx),
      .entry      (entry)
   );

   i2c_master i2c_master_inst (
      .CLK_400K     (CLK_400K),
      .RESET_N      (RESET_N),
      .cmd          (cmd),
      .start        (start),
      .sda_in       (sda_in),
      .scl          (i2c_scl),
      .sda_pull_low (sda_pull_low),
      .done         (done),
      .rdata        (rdata)
   );

endmodule

/* src/config_sequencer.sv */
`timescale 1ns/1ps

module config_sequencer (
   input  logic                             CLK_400K,
   input  logic                             RESET_N,
   output camera_config_pkg::i2c_cmd_t      cmd,
   output logic                             start,
   input  logic                             done,
   input  camera_config_pkg::reg_data_t     rdata,
   output camera_config_pkg::script_idx_t   script_idx,
   input  camera_config_pkg::script_entry_t entry,
   output camera_config_pkg::reg_data_t     chip_id,
   output logic                             config_done
);

   import camera_config_pkg::*;

   seq_state_t state;
   logic [8:0] wait_cnt;     // gap and delay counter, delay needs data + 1
   logic       gap_over;
   logic       last_entry;
   logic       is_delay;

   assign gap_over   = (wait_cnt == 9'(BUS_GAP_CYCLES - 1));
   assign last_entry = (script_idx == script_idx_t'(SCRIPT_LEN - 1));
   assign is_delay   = (entry.slave_addr == DELAY_MARKER);

   // request decoded from state, start is a single cycle
   always_comb begin
      cmd.op         = OP_WRITE_PTR;
      cmd.slave_addr = SENSOR_ADDR;
      cmd.reg_addr   = ID_REG;
      cmd.wdata      = '0;
      start          = 1'b0;
      case (state)
         SEQ_PTR: start = 1'b1;
         SEQ_READ: begin
            cmd.op = OP_READ_BYTE;
            start  = 1'b1;
         end
         SEQ_ENTRY: begin
            cmd.op         = OP_WRITE_WORD;
            cmd.slave_addr = entry.slave_addr;
            cmd.reg_addr   = entry.reg_addr;
            cmd.wdata      = entry.data;
            start          = !is_delay;
         end
         default: ;
      endcase
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state       <= SEQ_PTR;
         wait_cnt    <= '0;
         script_idx  <= '0;
         chip_id     <= '0;
         config_done <= 1'b0;
      end else begin
         case (state)
            SEQ_PTR:      state <= SEQ_PTR_WAIT;
            SEQ_PTR_WAIT: begin
               wait_cnt <= '0;
               if (done) state <= SEQ_PTR_GAP;
            end
            SEQ_PTR_GAP: begin
               wait_cnt <= wait_cnt + 9'd1;
               if (gap_over) state <= SEQ_READ;
            end
            SEQ_READ:     state <= SEQ_READ_WAIT;
            SEQ_READ_WAIT: begin
               wait_cnt <= '0;
               if (done) begin
                  chip_id <= rdata;
                  state   <= SEQ_ID_GAP;
               end
            end
            SEQ_ID_GAP: begin
               wait_cnt <= wait_cnt + 9'd1;
               if (gap_over) begin
                  script_idx <= '0;
                  state      <= (chip_id == EXPECTED_ID) ? SEQ_FETCH : SEQ_PTR;  // retry
               end
            end
            SEQ_FETCH:    state <= SEQ_ENTRY;             // rom latency
            SEQ_ENTRY: begin
               wait_cnt <= '0;
               state    <= is_delay ? SEQ_DELAY : SEQ_WORD_WAIT;
            end
            SEQ_WORD_WAIT: begin
               if (done) begin
                  if (last_entry) begin
                     config_done <= 1'b1;
                     state       <= SEQ_DONE;
                  end else begin
                     state <= SEQ_GAP;
                  end
               end
            end
            SEQ_GAP: begin
               wait_cnt <= wait_cnt + 9'd1;
               if (gap_over) begin
                  script_idx <= script_idx + script_idx_t'(1);
                  state      <= SEQ_FETCH;
               end
            end
            SEQ_DELAY: begin
               wait_cnt <= wait_cnt + 9'd1;
               if (wait_cnt == {1'b0, entry.data}) begin   // data + 1 cycles
                  if (last_entry) begin
                     config_done <= 1'b1;
                     state       <= SEQ_DONE;
                  end else begin
                     script_idx <= script_idx + script_idx_t'(1);
                     state      <= SEQ_FETCH;
                  end
               end
            end
            SEQ_DONE:     state <= SEQ_DONE;              // bus stays idle
            default:      state <= SEQ_PTR;
         endcase
      end
   end

endmodule

/* src/i2c_master.sv */
`timescale 1ns/1ps

module i2c_master (
   input  logic                        CLK_400K,
   input  logic                        RESET_N,
   input  camera_config_pkg::i2c_cmd_t cmd,
   input  logic                        start,
   input  logic                        sda_in,
   output logic                        scl,
   output logic                        sda_pull_low,
   output logic                        done,
   output camera_config_pkg::reg_data_t rdata
);

   import camera_config_pkg::*;

   i2c_state_t state;
   i2c_op_t    op_r;
   tick_cnt_t  tick_cnt;
   logic [1:0] quarter;      // quarter of the current scl period
   logic [3:0] bit_cnt;      // 0..7 data, 8 is the ack slot
   logic [1:0] byte_cnt;
   logic [1:0] last_byte;
   logic [31:0] tx_sr;       // bytes to send, msb goes out first
   logic [7:0]  rx_sr;
   logic        quarter_tick;
   logic        phase_end;
   logic        rx_byte;

   assign quarter_tick = (tick_cnt == tick_cnt_t'(QUARTER_CYCLES - 1));
   assign phase_end    = quarter_tick && (quarter == 2'd3);
   assign rx_byte      = (op_r == OP_READ_BYTE) && (byte_cnt == 2'd1);
   assign rdata        = rx_sr;

   always_comb begin
      case (op_r)
         OP_WRITE_PTR:  last_byte = 2'd2;
         OP_WRITE_WORD: last_byte = 2'd3;
         default:       last_byte = 2'd1;  // address byte plus one read byte
      endcase
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state    <= I2C_IDLE;
         op_r     <= OP_WRITE_PTR;
         tick_cnt <= '0;
         quarter  <= '0;
         bit_cnt  <= '0;
         byte_cnt <= '0;
         done     <= 1'b0;
      end else begin
         done <= 1'b0;
         if (state == I2C_IDLE) begin
            tick_cnt <= '0;
            quarter  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            if (start) begin
               state <= I2C_START;
               op_r  <= cmd.op;
            end
         end else begin
            if (quarter_tick) begin
               tick_cnt <= '0;
               quarter  <= quarter + 2'd1;
            end else begin
               tick_cnt <= tick_cnt + tick_cnt_t'(1);
            end
            if (phase_end) begin
               case (state)
                  I2C_START: state <= I2C_BIT;
                  I2C_BIT: begin
                     if (bit_cnt == 4'd8) begin
                        bit_cnt <= '0;
                        if (byte_cnt == last_byte) begin
                           state <= I2C_STOP;
                        end else begin
                           byte_cnt <= byte_cnt + 2'd1;
                        end
                     end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                     end
                  end
                  I2C_STOP: begin
                     state <= I2C_IDLE;
                     done  <= 1'b1;          // one cycle after stop completes
                  end
                  default: state <= I2C_IDLE;
               endcase
            end
         end
      end
   end

   // shift registers, loaded on start and stepped per bit
   always_ff @(posedge CLK_400K) begin
      if (state == I2C_IDLE && start) begin
         if (cmd.op == OP_READ_BYTE) begin
            tx_sr <= {cmd.slave_addr[7:1], 1'b1, 24'h0};
         end else begin
            tx_sr <= {cmd.slave_addr, cmd.reg_addr, cmd.wdata};
         end
      end else if (state == I2C_BIT && phase_end && bit_cnt != 4'd8) begin
         tx_sr <= {tx_sr[30:0], 1'b0};
      end
      if (state == I2C_BIT && rx_byte && bit_cnt != 4'd8 && quarter == 2'd1 && quarter_tick) begin
         rx_sr <= {rx_sr[6:0], sda_in};       // first clock with scl high
      end
   end

   // pins decoded from the registered phase
   always_comb begin
      scl          = 1'b1;
      sda_pull_low = 1'b0;
      case (state)
         I2C_START: begin
            scl          = (quarter != 2'd3);
            sda_pull_low = (quarter != 2'd0);      // sda falls with scl high
         end
         I2C_BIT: begin
            scl          = (quarter == 2'd1) || (quarter == 2'd2);
            sda_pull_low = (bit_cnt != 4'd8) && !rx_byte && !tx_sr[31];
         end
         I2C_STOP: begin
            scl          = (quarter != 2'd0);
            sda_pull_low = (quarter < 2'd2);       // sda rises with scl high
         end
         default: ;
      endcase
   end

endmodule

/* src/reg_script_rom.sv */
`timescale 1ns/1ps

module reg_script_rom (
   input  logic                             CLK_400K,
   input  camera_config_pkg::script_idx_t   script_idx,
   output camera_config_pkg::script_entry_t entry
);

   import camera_config_pkg::*;

   // registered table, entry follows script_idx one clock later
   always_ff @(posedge CLK_400K) begin
      case (script_idx)
         5'd0:    entry <= {SENSOR_ADDR, 16'h0103, 8'h01};   // software reset
         5'd1:    entry <= {SENSOR_ADDR, 16'h0103, 8'h01};   // reset again
         5'd2:    entry <= {DELAY_MARKER, 16'h0000, 8'd10};  // settle after reset
         5'd3:    entry <= {SENSOR_ADDR, 16'h0100, 8'h00};   // standby
         5'd4:    entry <= {SENSOR_ADDR, 16'h0302, 8'd24};   // pll1 multiplier
         5'd5:    entry <= {SENSOR_ADDR, 16'h0303, 8'h00};   // pll1 divm
         5'd6:    entry <= {SENSOR_ADDR, 16'h0304, 8'd3};    // pll1 mipi div
         5'd7:    entry <= {SENSOR_ADDR, 16'h3018, 8'h72};   // mipi 4 lane
         5'd8:    entry <= {SENSOR_ADDR, 16'h3031, 8'h0a};   // 10-bit
         5'd9:    entry <= {SENSOR_ADDR, 16'h3700, 8'h48};   // sensor control
         5'd10:   entry <= {SENSOR_ADDR, 16'h3701, 8'h18};
         5'd11:   entry <= {SENSOR_ADDR, 16'h3702, 8'h50};
         5'd12:   entry <= {SENSOR_ADDR, 16'h3703, 8'h32};
         5'd13:   entry <= {SENSOR_ADDR, 16'h3704, 8'h28};
         5'd14:   entry <= {SENSOR_ADDR, 16'h3705, 8'h00};
         5'd15:   entry <= {SENSOR_ADDR, 16'h3808, 8'h02};   // x size hi, 640
         5'd16:   entry <= {SENSOR_ADDR, 16'h3809, 8'h80};   // x size lo
         5'd17:   entry <= {SENSOR_ADDR, 16'h380a, 8'h01};   // y size hi, 480
         5'd18:   entry <= {SENSOR_ADDR, 16'h380b, 8'he0};   // y size lo
         5'd19:   entry <= {DELAY_MARKER, 16'h0000, 8'd10};
         5'd20:   entry <= {SENSOR_ADDR, 16'h5018, 8'h19};   // red mwb gain
         5'd21:   entry <= {SENSOR_ADDR, 16'h501a, 8'h10};   // green mwb gain
         5'd22:   entry <= {SENSOR_ADDR, 16'h501c, 8'h17};   // blue mwb gain
         5'd23:   entry <= {SENSOR_ADDR, 16'h0100, 8'h01};   // wake up, streaming
         default: entry <= '0;
      endcase
   end

endmodule

/* verification/camera_config_props.sv */
`timescale 1ns/1ps

module camera_config_props (
   input logic CLK_400K,
   input logic RESET_N,
   input logic i2c_scl,
   input logic sda_pull_low,
   input logic config_done
);

   a_done_sticky: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      config_done |=> config_done)
      else $error("config_done fell");

   // with scl high the only sda moves are start (idle before) and stop (scl just rose)
   a_sda_stable: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      (i2c_scl && $past(i2c_scl) && $changed(sda_pull_low)) |->
         (($rose(sda_pull_low) && $past(i2c_scl, 2)) ||
          ($fell(sda_pull_low) && !$past(i2c_scl, 2))))
      else $error("sda changed while scl high outside start or stop");

   a_no_start_after_done: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      config_done |-> !(i2c_scl && $rose(sda_pull_low)))
      else $error("start condition after config_done");

endmodule

bind camera_config_top camera_config_props props_inst (
   .CLK_400K     (CLK_400K),
   .RESET_N      (RESET_N),
   .i2c_scl      (i2c_scl),
   .sda_pull_low (sda_pull_low),
   .config_done  (config_done)
);

/* verification/camera_config_tb.sv */
`timescale 1ns/1ps

module camera_config_tb;

   import camera_config_pkg::*;

   logic          CLK_400K;
   logic          RESET_N;
   logic          sda_in;
   logic          i2c_scl;
   logic          sda_pull_low;
   logic          config_done;
   reg_data_t     chip_id;
   reg_data_t     id_value;
   logic          model_pull;
   logic          rec_valid;
   logic [1:0]    rec_kind;
   script_entry_t rec;
   script_entry_t exp_rec;
   logic          start_seen;
   integer        seed;
   int            wrong_n;
   int            read_cnt = 0;
   int            word_cnt = 0;
   int            start_cnt = 0;
   int            starts_at_done;
   logic          ptr_seen = 1'b0;
   logic          id_ok = 1'b0;
   reg_data_t     last_id = '0;

   assign sda_in = !(sda_pull_low || model_pull);   // wired-and bus

   camera_config_top camera_config_top_inst (
      .CLK_400K     (CLK_400K),
      .RESET_N      (RESET_N),
      .sda_in       (sda_in),
      .i2c_scl      (i2c_scl),
      .sda_pull_low (sda_pull_low),
      .config_done  (config_done),
      .chip_id      (chip_id)
   );

   sensor_i2c_model sensor_i2c_model_inst (
      .clk        (CLK_400K),
      .rst_n      (RESET_N),
      .scl        (i2c_scl),
      .sda        (sda_in),
      .id_value   (id_value),
      .pull_low   (model_pull),
      .rec_valid  (rec_valid),
      .rec_kind   (rec_kind),
      .rec        (rec),
      .start_seen (start_seen)
   );

   initial begin
      CLK_400K = 1'b0;
      forever #10 CLK_400K = !CLK_400K;
   end

   // nth bus write of the script, pause entries skipped
   function automatic script_entry_t expected_write(input int n);
      case (n)
         0, 1:    return {8'h6c, 16'h0103, 8'h01};
         2:       return {8'h6c, 16'h0100, 8'h00};
         3:       return {8'h6c, 16'h0302, 8'h18};
         4:       return {8'h6c, 16'h0303, 8'h00};
         5:       return {8'h6c, 16'h0304, 8'h03};
         6:       return {8'h6c, 16'h3018, 8'h72};
         7:       return {8'h6c, 16'h3031, 8'h0a};
         8:       return {8'h6c, 16'h3700, 8'h48};
         9:       return {8'h6c, 16'h3701, 8'h18};
         10:      return {8'h6c, 16'h3702, 8'h50};
         11:      return {8'h6c, 16'h3703, 8'h32};
         12:      return {8'h6c, 16'h3704, 8'h28};
         13:      return {8'h6c, 16'h3705, 8'h00};
         14:      return {8'h6c, 16'h3808, 8'h02};
         15:      return {8'h6c, 16'h3809, 8'h80};
         16:      return {8'h6c, 16'h380a, 8'h01};
         17:      return {8'h6c, 16'h380b, 8'he0};
         18:      return {8'h6c, 16'h5018, 8'h19};
         19:      return {8'h6c, 16'h501a, 8'h10};
         20:      return {8'h6c, 16'h501c, 8'h17};
         21:      return {8'h6c, 16'h0100, 8'h01};
         default: return '0;
      endcase
   endfunction

   task automatic fail_run();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got == exp) else begin
         $display("FAIL %s: got 0x%0h expected 0x%0h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      assert (cond) else begin
         $display("%s", msg);
         fail_run();
      end
   endtask

   // compare process, one bus record at a time
   always @(posedge CLK_400K) begin
      if (start_seen) start_cnt++;
      if (RESET_N && word_cnt < 22) check_value("config_done", 32'(config_done), 32'h0);
      if (rec_valid) begin
         case (rec_kind)
            2'd0: begin
               check_true(!id_ok, "pointer write after the ID was accepted");
               check_value("rec.slave_addr", 32'(rec.slave_addr), 32'h6c);
               check_value("rec.reg_addr", 32'(rec.reg_addr), 32'h300b);
               if (read_cnt > 0) check_value("chip_id", 32'(chip_id), 32'(last_id));
               ptr_seen = 1'b1;
            end
            2'd2: begin
               check_true(ptr_seen, "ID read without a pointer write before it");
               check_value("rec.slave_addr", 32'(rec.slave_addr), 32'h6d);
               ptr_seen = 1'b0;
               last_id  = id_value;
               read_cnt++;
               if (last_id == 8'h88) id_ok = 1'b1;
               id_value <= (read_cnt < wrong_n) ? reg_data_t'(8'h3c + read_cnt) : 8'h88;
            end
            default: begin
               check_true(id_ok, "word write before the correct ID was read");
               check_true(word_cnt < 22, "more word writes than the script holds");
               check_value("chip_id", 32'(chip_id), 32'h88);
               exp_rec = expected_write(word_cnt);
               check_value("rec.slave_addr", 32'(rec.slave_addr), 32'(exp_rec.slave_addr));
               check_value("rec.reg_addr", 32'(rec.reg_addr), 32'(exp_rec.reg_addr));
               check_value("rec.data", 32'(rec.data), 32'(exp_rec.data));
               word_cnt++;
            end
         endcase
      end
   end

   initial begin
      int cyc;
      seed     = 32'hd108383e;
      wrong_n  = int'($unsigned($random(seed)) % 4);   // wrong IDs before 0x88
      RESET_N  <= 1'b0;
      id_value <= (wrong_n > 0) ? 8'h3c : 8'h88;
      repeat (8) @(posedge CLK_400K);
      RESET_N <= 1'b1;

      // idle bus until the DUT first pulls sda low
      cyc = 0;
      @(negedge CLK_400K);
      while (!sda_pull_low) begin
         check_value("i2c_scl", 32'(i2c_scl), 32'h1);
         check_value("config_done", 32'(config_done), 32'h0);
         check_value("chip_id", 32'(chip_id), 32'h0);
         cyc++;
         if (cyc > 200) begin
            $display("timeout waiting for the first start condition");
            fail_run();
         end
         @(negedge CLK_400K);
      end
      check_value("i2c_scl", 32'(i2c_scl), 32'h1);   // first sda fall is a start

      cyc = 0;
      while (!config_done) begin
         @(posedge CLK_400K);
         cyc++;
         if (cyc > 30000) begin
            $display("timeout waiting for config_done");
            fail_run();
         end
      end
      check_value("word_cnt", 32'(word_cnt), 32'd22);
      check_value("read_cnt", 32'(read_cnt), 32'(wrong_n + 1));

      starts_at_done = start_cnt;
      cyc = 0;
      while (cyc < 2000) begin
         @(posedge CLK_400K);
         check_value("config_done", 32'(config_done), 32'h1);
         cyc++;
      end
      check_true(start_cnt == starts_at_done, "start condition after config_done");
      $display("PASS: all tests");
      $finish;
   end

endmodule

/* verification/sensor_i2c_model.sv */
`timescale 1ns/1ps

module sensor_i2c_model (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             scl,
   input  logic                             sda,
   input  camera_config_pkg::reg_data_t     id_value,
   output logic                             pull_low,
   output logic                             rec_valid,
   output logic [1:0]                       rec_kind,   // 0 pointer, 1 word, 2 read
   output camera_config_pkg::script_entry_t rec,
   output logic                             start_seen
);

   import camera_config_pkg::*;

   logic       prev_scl = 1'b1;
   logic       prev_sda = 1'b1;
   logic       active;
   logic       skip_fall;   // scl fall that ends the start condition
   logic       next_pull;
   logic [3:0] bit_cnt;
   logic [2:0] byte_cnt;
   logic [7:0] shift;
   logic [7:0] tx;
   logic [7:0] bytes [0:3];
   logic       is_read;

   assign is_read = bytes[0][0];

   // bus decoded on the falling clock, where scl and sda are settled
   always @(negedge clk) begin
      if (!rst_n) begin
         active     <= 1'b0;
         skip_fall  <= 1'b0;
         next_pull  <= 1'b0;
         bit_cnt    <= '0;
         byte_cnt   <= '0;
         rec_valid  <= 1'b0;
         rec_kind   <= '0;
         rec        <= '0;
         start_seen <= 1'b0;
         bytes[0]   <= '0;
      end else begin
         rec_valid  <= 1'b0;
         start_seen <= 1'b0;
         if (prev_scl && scl && prev_sda && !sda) begin        // start
            active     <= 1'b1;
            skip_fall  <= 1'b1;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            next_pull  <= 1'b0;
            start_seen <= 1'b1;
         end else if (prev_scl && scl && !prev_sda && sda && active) begin  // stop
            active    <= 1'b0;
            next_pull <= 1'b0;
            rec_valid <= 1'b1;
            if (byte_cnt == 3'd4) begin
               rec_kind <= 2'd1;
               rec      <= {bytes[0], bytes[1], bytes[2], bytes[3]};
            end else if (byte_cnt == 3'd2 && is_read) begin
               rec_kind <= 2'd2;
               rec      <= {bytes[0], 16'h0000, tx};
            end else begin
               rec_kind <= 2'd0;
               rec      <= {bytes[0], bytes[1], bytes[2], 8'h00};
            end
         end else if (active && !prev_scl && scl && bit_cnt < 4'd8) begin
            shift <= {shift[6:0], sda};
         end else if (active && prev_scl && !scl) begin
            if (skip_fall) begin
               skip_fall <= 1'b0;
            end else if (bit_cnt == 4'd7) begin
               bit_cnt <= 4'd8;
               if (byte_cnt < 3'd4) bytes[byte_cnt[1:0]] <= shift;
               next_pull <= !(byte_cnt == 3'd1 && is_read);   // ack, master nacks reads
            end else if (bit_cnt == 4'd8) begin
               bit_cnt  <= '0;
               byte_cnt <= byte_cnt + 3'd1;
               if (byte_cnt == 3'd0 && is_read) begin
                  tx        <= id_value;
                  next_pull <= !id_value[7];
               end else begin
                  next_pull <= 1'b0;
               end
            end else begin
               bit_cnt <= bit_cnt + 4'd1;
               if (byte_cnt == 3'd1 && is_read)
                  next_pull <= !tx[3'd6 - bit_cnt[2:0]];
               else
                  next_pull <= 1'b0;
            end
         end
         prev_scl <= scl;
         prev_sda <= sda;
      end
   end

   always @(posedge clk) begin
      pull_low <= rst_n ? next_pull : 1'b0;
   end

endmodule
